// File: vlog.f
+incdir+rtl
rtl/fetch_align_pkg.sv
rtl/parcel_buffer.sv
rtl/refill_unit.sv
rtl/fetch_align_top.sv
tests/align_checker.sv
tests/tb_fetch_align.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch align testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_fetch_align \
  -Mdir obj_dir -o sim_fetch_align
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_fetch_align > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tests/tb_fetch_align.sv
// testbench top with clock, reset, directed and xorshift fetches, memory model and checker
`timescale 1ns/1ps
`default_nettype none
`include "fetch_align_cfg.svh"

module tb_fetch_align;

  localparam logic [31:0] seed          = 32'he030_56b6;
  localparam int          fetch_timeout = 200;

  logic                        clk;
  logic                        rst_n;
  fetch_align_pkg::fetch_req_t fetch_req;
  fetch_align_pkg::fetch_res_t fetch_res;
  fetch_align_pkg::mem_req_t   mem_req;
  fetch_align_pkg::mem_res_t   mem_res;
  logic                        mem_ready;
  int                          exp_hs;
  int                          exp_lat;
  int                          err_cnt;
  int                          chk_cnt;
  logic                        timed_out;
  // separate streams for stimulus and memory behaviour
  logic [31:0]                 stim_rng;
  logic [31:0]                 mem_rng;

  fetch_align_top u_fetch_align_top (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .fetch_req_i (fetch_req),
    .fetch_res_o (fetch_res),
    .mem_req_o   (mem_req),
    .mem_ready_i (mem_ready),
    .mem_res_i   (mem_res)
  );

  align_checker u_checker (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .fetch_req_i (fetch_req),
    .fetch_res_i (fetch_res),
    .mem_req_i   (mem_req),
    .mem_ready_i (mem_ready),
    .exp_hs_i    (exp_hs),
    .exp_lat_i   (exp_lat),
    .err_cnt_o   (err_cnt),
    .chk_cnt_o   (chk_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory content hashed from the halfword address
  function automatic fetch_align_pkg::parcel_t parcel_at(input fetch_align_pkg::addr_t a);
    logic [31:0] h;
    h = xorshift32(xorshift32({a[`FA_XLEN-1:1], 1'b0} ^ seed));
    return h[15:0];
  endfunction

  function automatic fetch_align_pkg::block_t block_at(input fetch_align_pkg::addr_t base);
    fetch_align_pkg::parcel_t [`FA_BLK_BITS/`FA_PARCEL_BITS-1:0] p;
    for (int i = 0; i < `FA_BLK_BITS / `FA_PARCEL_BITS; i++) begin
      p[i] = parcel_at(base + 32'(2 * i));
    end
    return p;
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // memory model
  ////////////////////

  initial begin : mem_model
    logic                   take;
    logic                   pend;
    fetch_align_pkg::addr_t take_addr;
    fetch_align_pkg::addr_t pend_addr;
    int unsigned            delay;
    mem_ready = 1'b0;
    mem_res   = '0;
    mem_rng   = xorshift32(seed);
    pend      = 1'b0;
    delay     = 0;
    forever begin
      @(posedge clk);
      take      = mem_req.valid && mem_ready;
      take_addr = mem_req.addr;
      #1;
      mem_res = '0;
      if (!rst_n) begin
        pend = 1'b0;
      end else if (take) begin
        pend      = 1'b1;
        pend_addr = take_addr;
        mem_rng   = xorshift32(mem_rng);
        delay     = mem_rng % 4;
      end else if (pend) begin
        if (delay == 0) begin
          mem_res.valid = 1'b1;
          mem_res.blk   = block_at(pend_addr);
          pend          = 1'b0;
        end else begin
          delay--;
        end
      end
      // ready about three cycles in four
      mem_rng   = xorshift32(mem_rng);
      mem_ready = mem_rng[0] | mem_rng[1];
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  // hold the request until the response, then drop valid for a cycle
  task automatic fetch_window(input fetch_align_pkg::addr_t addr, input logic uncached,
                              input int hs, input int lat);
    int cycles;
    cycles = 0;
    if (!timed_out) begin
      @(posedge clk);
      #1;
      fetch_req.valid    = 1'b1;
      fetch_req.addr     = addr;
      fetch_req.uncached = uncached;
      exp_hs             = hs;
      exp_lat            = lat;
      do begin
        @(posedge clk);
        cycles++;
      end while (!fetch_res.valid && cycles < fetch_timeout);
      if (!fetch_res.valid) begin
        $display("timeout waiting for fetch response at address %h", addr);
        timed_out = 1'b1;
      end
      #1;
      fetch_req.valid = 1'b0;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (timed_out) begin
      $display("test %s: stopped by timeout", name);
    end else if (err_cnt == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - err_before);
    end
  endtask

  initial begin : stimulus
    int                     e;
    fetch_align_pkg::addr_t a;
    logic                   unc;
    fetch_req = '0;
    exp_hs    = -1;
    exp_lat   = -1;
    timed_out = 1'b0;
    stim_rng  = seed;
    rst_n     = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    e = err_cnt;
    fetch_window(32'h100, 1'b0, 1, -1);
    fetch_window(32'h100, 1'b0, 0, 1);
    report_test("cold miss then hit", e);

    // next block first so the last offset hits too
    e = err_cnt;
    fetch_window(32'h110, 1'b0, 1, -1);
    for (int i = 0; i < 8; i++) begin
      fetch_window(32'h100 + 32'(2 * i), 1'b0, 0, 1);
    end
    report_test("every parcel offset", e);

    e = err_cnt;
    fetch_window(32'h23e, 1'b0, 2, -1);
    fetch_window(32'h23e, 1'b0, 0, 1);
    report_test("block straddle", e);

    // uncached data leaves the buffer untouched
    e = err_cnt;
    fetch_window(32'h344, 1'b1, 1, -1);
    fetch_window(32'h344, 1'b0, 1, -1);
    report_test("uncached fetch", e);

    // same set, different tags
    e = err_cnt;
    fetch_window(32'h480, 1'b0, 1, -1);
    fetch_window(32'h680, 1'b0, 1, -1);
    fetch_window(32'h480, 1'b0, 1, -1);
    report_test("conflict eviction", e);

    e = err_cnt;
    for (int i = 0; i < 200; i++) begin
      stim_rng = xorshift32(stim_rng);
      a        = stim_rng & 32'h7fe;
      stim_rng = xorshift32(stim_rng);
      unc      = (stim_rng % 10) == 0;
      fetch_window(a, unc, -1, -1);
    end
    report_test("random stream", e);

    $display("fetches checked %0d, errors %0d", chk_cnt, err_cnt);
    if (timed_out || err_cnt != 0 || chk_cnt == 0) begin
      $display("Finished with errors");
    end else begin
      $display("Finished with no errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/align_checker.sv
// fetch response checker with reference window, refill handshake tracking and error counts
`timescale 1ns/1ps
`default_nettype none
`include "fetch_align_cfg.svh"

module align_checker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  fetch_align_pkg::fetch_req_t fetch_req_i,
  input  fetch_align_pkg::fetch_res_t fetch_res_i,
  input  fetch_align_pkg::mem_req_t   mem_req_i,
  input  logic                        mem_ready_i,
  // expected handshakes and latency of the fetch in flight, negative means any
  input  int                          exp_hs_i,
  input  int                          exp_lat_i,
  output int                          err_cnt_o,
  output int                          chk_cnt_o
);

  localparam logic [31:0] seed = 32'he030_56b6;

  logic                     vld_q;
  // cycles since the request was first seen
  int                       lat;
  int                       hs_cnt;
  fetch_align_pkg::addr_t   first_hs_addr;
  fetch_align_pkg::addr_t   second_hs_addr;

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // instruction memory content, one hash per halfword address
  function automatic fetch_align_pkg::parcel_t parcel_at(input fetch_align_pkg::addr_t a);
    logic [31:0] h;
    h = xorshift32(xorshift32({a[`FA_XLEN-1:1], 1'b0} ^ seed));
    return h[15:0];
  endfunction

  // lower parcel at the address, upper parcel two bytes on
  function automatic fetch_align_pkg::window_t ref_window(input fetch_align_pkg::addr_t a);
    return {parcel_at(a + 32'd2), parcel_at(a)};
  endfunction

  task automatic report_mismatch(input string msg);
    err_cnt_o++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  ////////////////////
  // response compare
  ////////////////////

  task automatic check_response();
    fetch_align_pkg::addr_t   blk;
    fetch_align_pkg::window_t exp_win;
    exp_win = ref_window(fetch_req_i.addr);
    blk     = fetch_req_i.addr & ~fetch_align_pkg::addr_t'(`FA_BLK_BYTES - 1);
    chk_cnt_o++;
    if (fetch_res_i.window !== exp_win) begin
      report_mismatch($sformatf("addr %h window %h expected %h",
                                fetch_req_i.addr, fetch_res_i.window, exp_win));
    end
    if (exp_lat_i >= 0 && lat != exp_lat_i) begin
      report_mismatch($sformatf("addr %h latency %0d expected %0d",
                                fetch_req_i.addr, lat, exp_lat_i));
    end
    if (exp_hs_i >= 0 && hs_cnt != exp_hs_i) begin
      report_mismatch($sformatf("addr %h memory handshakes %0d expected %0d",
                                fetch_req_i.addr, hs_cnt, exp_hs_i));
    end
    // request block goes first, the next block second
    if (exp_hs_i >= 1 && hs_cnt >= 1 && first_hs_addr !== blk) begin
      report_mismatch($sformatf("addr %h first refill %h expected %h",
                                fetch_req_i.addr, first_hs_addr, blk));
    end
    if (exp_hs_i == 2 && hs_cnt >= 2 && second_hs_addr !== blk + `FA_BLK_BYTES) begin
      report_mismatch($sformatf("addr %h second refill %h expected %h",
                                fetch_req_i.addr, second_hs_addr, blk + `FA_BLK_BYTES));
    end
  endtask

  // everything sampled on the rising edge, inputs move 1 ns later
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      vld_q     = 1'b0;
      lat       = 0;
      hs_cnt    = 0;
      err_cnt_o = 0;
      chk_cnt_o = 0;
    end else begin
      if (fetch_req_i.valid && !vld_q) begin
        lat    = 0;
        hs_cnt = 0;
      end else if (fetch_req_i.valid) begin
        lat++;
      end
      if (mem_req_i.valid && mem_ready_i) begin
        if (hs_cnt == 0) begin
          first_hs_addr = mem_req_i.addr;
        end else if (hs_cnt == 1) begin
          second_hs_addr = mem_req_i.addr;
        end
        hs_cnt++;
      end
      if (fetch_req_i.valid && fetch_res_i.valid) begin
        check_response();
      end
      vld_q = fetch_req_i.valid;
    end
  end

endmodule

`default_nettype wire

// File: rtl/fetch_align_top.sv
// fetch align top joining the parcel buffer and the refill unit
`timescale 1ns/1ps
`default_nettype none

module fetch_align_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // fetch side, request held until the response
  input  fetch_align_pkg::fetch_req_t fetch_req_i,
  output fetch_align_pkg::fetch_res_t fetch_res_o,
  // instruction memory, one block read at a time
  output fetch_align_pkg::mem_req_t   mem_req_o,
  input  logic                        mem_ready_i,
  input  fetch_align_pkg::mem_res_t   mem_res_i
);

  // miss request and returned block between the two halves
  fetch_align_pkg::fill_req_t fill_req;
  fetch_align_pkg::fill_res_t fill_res;

  ////////////////////
  // lookup and combine
  ////////////////////

  parcel_buffer u_parcel_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_req_i (fetch_req_i),
    .fetch_res_o (fetch_res_o),
    .fill_req_o  (fill_req),
    .fill_res_i  (fill_res)
  );

  ////////////////////
  // block refill
  ////////////////////

  refill_unit u_refill_unit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fill_req_i  (fill_req),
    .fill_res_o  (fill_res),
    .mem_req_o   (mem_req_o),
    .mem_ready_i (mem_ready_i),
    .mem_res_i   (mem_res_i)
  );

endmodule

`default_nettype wire

// File: rtl/refill_unit.sv
// refill FSM turning buffer misses into single block reads on the instruction memory port
`timescale 1ns/1ps
`default_nettype none

module refill_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  fetch_align_pkg::fill_req_t fill_req_i,
  output fetch_align_pkg::fill_res_t fill_res_o,
  output fetch_align_pkg::mem_req_t  mem_req_o,
  input  logic                       mem_ready_i,
  input  fetch_align_pkg::mem_res_t  mem_res_i
);

  fetch_align_pkg::refill_state_e state_q;
  fetch_align_pkg::refill_state_e state_d;
  // block address of the refill in flight
  fetch_align_pkg::addr_t         addr_q;
  // returned block, held for the DONE pulse
  fetch_align_pkg::block_t        blk_q;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      fetch_align_pkg::IDLE: begin
        if (fill_req_i.valid) begin
          state_d = fetch_align_pkg::REQ;
        end
      end
      // request held until the memory takes it
      fetch_align_pkg::REQ: begin
        if (mem_ready_i) begin
          state_d = fetch_align_pkg::WAIT;
        end
      end
      fetch_align_pkg::WAIT: begin
        if (mem_res_i.valid) begin
          state_d = fetch_align_pkg::DONE;
        end
      end
      // single pulse, then idle so the buffer re-checks its tags
      fetch_align_pkg::DONE: begin
        state_d = fetch_align_pkg::IDLE;
      end
      default: begin
        state_d = fetch_align_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= fetch_align_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // address captured on accept, block on the memory response
  always_ff @(posedge clk_i) begin
    if (state_q == fetch_align_pkg::IDLE && fill_req_i.valid) begin
      addr_q <= fill_req_i.addr;
    end
    if (state_q == fetch_align_pkg::WAIT && mem_res_i.valid) begin
      blk_q <= mem_res_i.blk;
    end
  end

  ////////////////////
  // outputs
  ////////////////////

  always_comb begin
    mem_req_o.valid  = (state_q == fetch_align_pkg::REQ);
    mem_req_o.addr   = addr_q;
    fill_res_o.valid = (state_q == fetch_align_pkg::DONE);
    fill_res_o.blk   = blk_q;
  end

endmodule

`default_nettype wire

// File: rtl/parcel_buffer.sv
// even/odd parcel banks, tag store, dual tag compare, miss request and window combining
`timescale 1ns/1ps
`default_nettype none
`include "fetch_align_cfg.svh"

module parcel_buffer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  fetch_align_pkg::fetch_req_t fetch_req_i,
  output fetch_align_pkg::fetch_res_t fetch_res_o,
  output fetch_align_pkg::fill_req_t  fill_req_o,
  input  fetch_align_pkg::fill_res_t  fill_res_i
);

  // parcel pairs per bank row and parcels per block
  localparam int unsigned bank_words  = `FA_BLK_BITS / (2 * `FA_PARCEL_BITS);
  localparam int unsigned blk_parcels = `FA_BLK_BITS / `FA_PARCEL_BITS;

  // parcel pair inside a block, and single parcel inside a block
  typedef logic [`FA_OFF_BITS-3:0] word_sel_t;
  typedef logic [`FA_OFF_BITS-2:0] parcel_sel_t;

  // one side of the gray lookup
  typedef struct packed {
    fetch_align_pkg::idx_t    idx;
    fetch_align_pkg::tag_t    tag;
    word_sel_t                word;
    logic                     hit;
    fetch_align_pkg::parcel_t parcel;
  } side_t;

  ////////////////////
  // storage
  ////////////////////

  // even bank holds parcels 0,2,4,6 and odd bank holds 1,3,5,7
  fetch_align_pkg::parcel_t even_bank [`FA_NUM_SETS][bank_words];
  fetch_align_pkg::parcel_t odd_bank  [`FA_NUM_SETS][bank_words];
  fetch_align_pkg::tag_t    tag_mem   [`FA_NUM_SETS];
  logic [`FA_NUM_SETS-1:0]  tag_vld_q;

  logic                     req_vld_q;
  // response already given for the held request
  logic                     served_q;
  // first half of a straddling uncached window is parked
  logic                     lo_held_q;
  fetch_align_pkg::parcel_t lo_hold_q;

  side_t                    even_s;
  side_t                    odd_s;
  parcel_sel_t              parcel_off;
  parcel_sel_t              upper_off;
  logic                     unalign;
  logic                     check;
  logic                     both_hit;
  logic                     alloc;
  logic                     hold_lo;
  fetch_align_pkg::blk_num_t odd_blk;
  fetch_align_pkg::blk_num_t even_blk;
  fetch_align_pkg::blk_num_t fill_blk;
  fetch_align_pkg::idx_t    fill_idx;
  fetch_align_pkg::tag_t    fill_tag;
  fetch_align_pkg::parcel_t [blk_parcels-1:0] fill_parcels;
  fetch_align_pkg::parcel_t uncached_lo;
  fetch_align_pkg::window_t cached_win;
  fetch_align_pkg::window_t uncached_win;

  ////////////////////
  // lookup
  ////////////////////

  always_comb begin
    parcel_off = fetch_req_i.addr[`FA_OFF_BITS-1:1];
    // last parcel of the block, upper half lives in the next block
    unalign    = &parcel_off;
    odd_blk    = fetch_req_i.addr[`FA_XLEN-1:`FA_OFF_BITS];
    // index overflow carries into the tag here
    even_blk   = odd_blk + fetch_align_pkg::blk_num_t'(unalign);

    odd_s.idx  = odd_blk[`FA_IDX_BITS-1:0];
    odd_s.tag  = odd_blk[`FA_XLEN-`FA_OFF_BITS-1:`FA_IDX_BITS];
    even_s.idx = even_blk[`FA_IDX_BITS-1:0];
    even_s.tag = even_blk[`FA_XLEN-`FA_OFF_BITS-1:`FA_IDX_BITS];

    // both tags compared in parallel
    odd_s.hit  = tag_vld_q[odd_s.idx] && (tag_mem[odd_s.idx] == odd_s.tag);
    even_s.hit = tag_vld_q[even_s.idx] && (tag_mem[even_s.idx] == even_s.tag);

    // odd start takes the even parcel of the next pair, wrapping to pair 0
    odd_s.word  = parcel_off[`FA_OFF_BITS-2:1];
    even_s.word = odd_s.word + word_sel_t'(fetch_req_i.addr[1]);
    odd_s.parcel  = odd_bank[odd_s.idx][odd_s.word];
    even_s.parcel = even_bank[even_s.idx][even_s.word];

    both_hit = odd_s.hit && even_s.hit;
    // tags are looked at from the second cycle of a request on
    check    = req_vld_q && fetch_req_i.valid && !served_q;
  end

  ////////////////////
  // miss request
  ////////////////////

  always_comb begin
    // uncached walks request block then next block; cached misses favour the odd side
    if (fetch_req_i.uncached) begin
      fill_blk = lo_held_q ? even_blk : odd_blk;
    end else begin
      fill_blk = odd_s.hit ? even_blk : odd_blk;
    end
    fill_idx = fill_blk[`FA_IDX_BITS-1:0];
    fill_tag = fill_blk[`FA_XLEN-`FA_OFF_BITS-1:`FA_IDX_BITS];

    fill_req_o.valid    = check && (fetch_req_i.uncached || !both_hit);
    fill_req_o.addr     = {fill_blk, {`FA_OFF_BITS{1'b0}}};
    fill_req_o.uncached = fetch_req_i.uncached;

    fill_parcels = fill_res_i.blk;
    // returned block is written only for cacheable requests
    alloc   = check && fill_res_i.valid && !fetch_req_i.uncached;
    hold_lo = check && fill_res_i.valid && fetch_req_i.uncached && unalign && !lo_held_q;
  end

  // banks and tags take the whole block in the fill cycle
  always_ff @(posedge clk_i) begin
    if (alloc) begin
      tag_mem[fill_idx] <= fill_tag;
      for (int w = 0; w < bank_words; w++) begin
        even_bank[fill_idx][w] <= fill_parcels[2*w];
        odd_bank[fill_idx][w]  <= fill_parcels[2*w+1];
      end
    end
    if (hold_lo) begin
      lo_hold_q <= fill_parcels[blk_parcels-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_vld_q <= 1'b0;
      served_q  <= 1'b0;
      lo_held_q <= 1'b0;
      tag_vld_q <= '0;
    end else begin
      req_vld_q <= fetch_req_i.valid;
      // per-request flags live until valid drops
      if (!fetch_req_i.valid) begin
        served_q  <= 1'b0;
        lo_held_q <= 1'b0;
      end else begin
        if (fetch_res_o.valid) begin
          served_q <= 1'b1;
        end
        if (hold_lo) begin
          lo_held_q <= 1'b1;
        end
      end
      if (alloc) begin
        tag_vld_q[fill_idx] <= 1'b1;
      end
    end
  end

  ////////////////////
  // window combining
  ////////////////////

  always_comb begin
    // odd start puts the odd parcel low
    cached_win = fetch_req_i.addr[1] ? {even_s.parcel, odd_s.parcel}
                                     : {odd_s.parcel, even_s.parcel};
    upper_off    = parcel_off + 1'b1;
    uncached_lo  = unalign ? lo_hold_q : fill_parcels[parcel_off];
    uncached_win = {fill_parcels[upper_off], uncached_lo};

    // uncached responds only in the fill pulse that completes the window
    fetch_res_o.valid  = check && (fetch_req_i.uncached ?
                                   (fill_res_i.valid && (!unalign || lo_held_q)) : both_hit);
    fetch_res_o.window = fetch_req_i.uncached ? uncached_win : cached_win;
  end

endmodule

`default_nettype wire

// File: rtl/fetch_align_pkg.sv
// width types, fetch/fill/memory request and response structs, refill FSM states
`default_nettype none
`include "fetch_align_cfg.svh"

package fetch_align_pkg;

  ////////////////////
  // width types
  ////////////////////

  typedef logic [`FA_XLEN-1:0]                addr_t;
  typedef logic [`FA_PARCEL_BITS-1:0]         parcel_t;
  // lower parcel is the one at the request address
  typedef logic [2*`FA_PARCEL_BITS-1:0]       window_t;
  // little-endian, parcel 0 in the low bits
  typedef logic [`FA_BLK_BITS-1:0]            block_t;
  // address with the block offset stripped, {tag, index}
  typedef logic [`FA_XLEN-`FA_OFF_BITS-1:0]   blk_num_t;
  typedef logic [`FA_IDX_BITS-1:0]            idx_t;
  typedef logic [`FA_TAG_BITS-1:0]            tag_t;

  ////////////////////
  // port structs
  ////////////////////

  typedef struct packed {logic valid; addr_t addr; logic uncached;} fetch_req_t;
  typedef struct packed {logic valid; window_t window;} fetch_res_t;

  // buffer to refill unit, addr is block aligned
  typedef struct packed {logic valid; addr_t addr; logic uncached;} fill_req_t;
  typedef struct packed {logic valid; block_t blk;} fill_res_t;

  // external instruction memory port
  typedef struct packed {logic valid; addr_t addr;} mem_req_t;
  typedef struct packed {logic valid; block_t blk;} mem_res_t;

  // refill sequencer
  typedef enum logic [1:0] {IDLE, REQ, WAIT, DONE} refill_state_e;

endpackage

`default_nettype wire

// File: rtl/fetch_align_cfg.svh
// fetch geometry macros for address width, block size, buffer capacity and derived field widths
`ifndef FETCH_ALIGN_CFG_SVH
`define FETCH_ALIGN_CFG_SVH

// byte address width
`define FA_XLEN 32

// one memory block, eight parcels
`define FA_BLK_BITS 128

// parcel buffer capacity in bytes
`define FA_BUF_BYTES 512

// one compressed instruction parcel
`define FA_PARCEL_BITS 16

////////////////////
// derived geometry
////////////////////

`define FA_BLK_BYTES (`FA_BLK_BITS / 8)
`define FA_NUM_SETS (`FA_BUF_BYTES / `FA_BLK_BYTES)
`define FA_OFF_BITS $clog2(`FA_BLK_BYTES)
`define FA_IDX_BITS $clog2(`FA_NUM_SETS)
`define FA_TAG_BITS (`FA_XLEN - `FA_IDX_BITS - `FA_OFF_BITS)

`endif
